// ==== list.f ====
src/ppc_pkg.sv
src/ppc_decode.sv
src/ppc_gpr.sv
src/ppc_alu.sv
src/ppc_bypass.sv
src/ppc_core.sv
sim/ppc_core_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --top-module ppc_core_tb -f list.f -o ppc_core_sim
out=$(./obj_dir/ppc_core_sim)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx 'RESULT: PASS'; then
	exit 0
fi
exit 1

// ==== sim/ppc_core_tb.sv ====
module ppc_core_tb;

	typedef struct packed {
		logic valid;
		logic hand; // value and cr0 below were worked out by hand
		logic [31:0] word;
		ppc_pkg::word_t value;
		logic [3:0] cr0; // lt gt eq so
		logic [2:0] test;
	} slot_t;

	typedef struct packed {
		ppc_pkg::retire_t exp;
		logic hand;
		ppc_pkg::word_t value;
		logic [3:0] cr0;
		logic [2:0] test;
	} expect_t;

	localparam int n_tests = 6;
	localparam int n_random = 200;

	logic clk;
	logic rst_n;
	logic instr_valid;
	ppc_pkg::instr_t instr;
	ppc_pkg::retire_t retire;

	slot_t slots[$];
	expect_t exp_q[$];
	ppc_pkg::word_t model_gpr [32];
	logic model_so;
	logic [31:0] lcg_state;
	string test_name [n_tests];
	int pending [n_tests];
	int test_err [n_tests];
	bit issued_all [n_tests];
	bit reported [n_tests];
	int cyc = 0;
	int limit = 0;
	int issue_cyc = -1000;
	int reset_slot = -1;
	bit first_seen = 1'b0;
	int cur_test = 0;
	int n_checks = 0;
	int n_errors = 0;

	ppc_core i_ppc_core (
		.clk(clk),
		.rst_n(rst_n),
		.instr_valid(instr_valid),
		.instr(instr),
		.retire(retire)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	always @(posedge clk) begin
		if (limit > 0 && cyc >= limit) begin
			$display("timeout after %0d cycles, %0d retires still missing", limit, exp_q.size());
			$display("RESULT: FAIL");
			$finish;
		end
	end

	function automatic logic [15:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[31:16]; // low bits of an lcg are weak
	endfunction

	function automatic logic [31:0] d_form(input logic [5:0] op, input logic [4:0] rt,
		input logic [4:0] ra, input logic [15:0] imm);
		return {op, rt, ra, imm};
	endfunction

	function automatic logic [31:0] x_form(input logic [4:0] rt, input logic [4:0] ra,
		input logic [4:0] rb, input logic oe, input logic [8:0] xo, input logic rc);
		return {ppc_pkg::op_x, rt, ra, rb, oe, xo, rc};
	endfunction

	function automatic logic [31:0] rlw_form(input logic [4:0] rs, input logic [4:0] ra,
		input logic [4:0] sh, input logic [4:0] mb, input logic [4:0] me, input logic rc);
		return {ppc_pkg::op_rlwinm, rs, ra, sh, mb, me, rc};
	endfunction

	function automatic ppc_pkg::word_t rotl(input ppc_pkg::word_t x, input logic [4:0] n);
		return (x << n) | (x >> (6'd32 - {1'b0, n}));
	endfunction

	function automatic ppc_pkg::word_t make_mask(input logic [4:0] mb, input logic [4:0] me);
		ppc_pkg::word_t m;
		bit in_run;
		m = '0;
		for (int i = 0; i < 32; i++) begin
			if (mb <= me)
				in_run = (i >= int'(mb)) && (i <= int'(me));
			else
				in_run = (i >= int'(mb)) || (i <= int'(me));
			if (in_run)
				m[31 - i] = 1'b1; // isa bit 0 is the msb
		end
		return m;
	endfunction

	function automatic logic [31:0] rand_instr();
		logic [31:0] s;
		logic [4:0] rt;
		logic [4:0] ra;
		logic [4:0] rb;
		int kind;
		kind = int'(lcg_next() % 16'd11);
		s = {lcg_next(), lcg_next()};
		rt = {2'b00, s[2:0]}; // few registers, many hazards
		ra = {2'b00, s[5:3]};
		rb = {2'b00, s[8:6]};
		case (kind)
			0: return d_form(ppc_pkg::op_addi, rt, ra, s[31:16]);
			1: return d_form(ppc_pkg::op_addis, rt, ra, s[31:16]);
			2: return d_form(ppc_pkg::op_ori, rt, ra, s[31:16]);
			3: return d_form(ppc_pkg::op_andi_rc, rt, ra, s[31:16]);
			4: return rlw_form(rt, ra, s[13:9], s[18:14], s[23:19], s[24]);
			5: return x_form(rt, ra, rb, s[25], ppc_pkg::xo_add, s[24]);
			6: return x_form(rt, ra, rb, s[25], ppc_pkg::xo_subf, s[24]);
			7: return x_form(rt, ra, rb, 1'b0, ppc_pkg::xo_and, s[24]);
			8: return x_form(rt, ra, rb, 1'b0, ppc_pkg::xo_or, s[24]);
			9: return x_form(rt, ra, rb, 1'b0, ppc_pkg::xo_xor, s[24]);
			default: return {6'd0, s[25:0]}; // opcode 0 is not implemented
		endcase
	endfunction

	task automatic push_slot(input logic valid, input logic hand, input logic [31:0] word,
		input ppc_pkg::word_t value, input logic [3:0] cr0, input int t);
		slot_t s;
		s.valid = valid;
		s.hand = hand;
		s.word = word;
		s.value = value;
		s.cr0 = cr0;
		s.test = 3'(t);
		slots.push_back(s);
	endtask

	task automatic add_row(input logic [31:0] word, input ppc_pkg::word_t value,
		input logic [3:0] cr0, input int t);
		push_slot(1'b1, 1'b1, word, value, cr0, t);
	endtask

	// executes one instruction in program order on the reference state
	task automatic model_step(input logic [31:0] w, output ppc_pkg::retire_t r);
		logic [4:0] f_t;
		logic [4:0] f_a;
		logic [4:0] f_b;
		ppc_pkg::word_t uimm;
		ppc_pkg::word_t res;
		ppc_pkg::reg_idx_t dest;
		longint wide;
		logic known;
		logic rc;
		logic ov;
		f_t = w[25:21];
		f_a = w[20:16];
		f_b = w[15:11];
		uimm = {16'h0000, w[15:0]};
		res = '0;
		dest = '0;
		wide = 0;
		known = 1'b1;
		rc = 1'b0;
		ov = 1'b0;
		case (w[31:26])
			ppc_pkg::op_addi, ppc_pkg::op_addis: begin
				res = (f_a == 5'd0) ? '0 : model_gpr[f_a];
				res = res + ((w[31:26] == ppc_pkg::op_addis) ? (uimm << 16)
					: {{16{w[15]}}, w[15:0]});
				dest = f_t;
			end
			ppc_pkg::op_ori: begin
				res = model_gpr[f_t] | uimm;
				dest = f_a;
			end
			ppc_pkg::op_andi_rc: begin
				res = model_gpr[f_t] & uimm;
				dest = f_a;
				rc = 1'b1;
			end
			ppc_pkg::op_rlwinm: begin
				res = rotl(model_gpr[f_t], w[15:11]) & make_mask(w[10:6], w[5:1]);
				dest = f_a;
				rc = w[0];
			end
			ppc_pkg::op_x: begin
				rc = w[0];
				case (w[9:1])
					ppc_pkg::xo_add, ppc_pkg::xo_subf: begin
						if (w[9:1] == ppc_pkg::xo_add)
							wide = longint'($signed(model_gpr[f_a]))
								+ longint'($signed(model_gpr[f_b]));
						else
							wide = longint'($signed(model_gpr[f_b]))
								- longint'($signed(model_gpr[f_a]));
						res = wide[31:0];
						ov = wide[32] ^ wide[31]; // exact result does not fit
						dest = f_t;
						if (w[10] && ov)
							model_so = 1'b1;
					end
					ppc_pkg::xo_and: begin
						res = model_gpr[f_t] & model_gpr[f_b];
						dest = f_a;
					end
					ppc_pkg::xo_or: begin
						res = model_gpr[f_t] | model_gpr[f_b];
						dest = f_a;
					end
					ppc_pkg::xo_xor: begin
						res = model_gpr[f_t] ^ model_gpr[f_b];
						dest = f_a;
					end
					default: known = 1'b0;
				endcase
			end
			default: known = 1'b0;
		endcase
		if (known)
			model_gpr[dest] = res;
		r.valid = 1'b1;
		r.wr_en = known;
		r.wr_idx = dest;
		r.value = res;
		r.cr0_wr = known & rc;
		r.cr0.lt = $signed(res) < 0;
		r.cr0.gt = $signed(res) > 0;
		r.cr0.eq = (res == '0);
		r.cr0.so = model_so;
	endtask

	// drain, then reset core and model together
	task automatic restart_core();
		@(posedge clk);
		#10;
		instr_valid = 1'b0;
		instr = '0;
		while (exp_q.size() != 0)
			@(posedge clk);
		#10;
		rst_n = 1'b0;
		model_so = 1'b0;
		for (int i = 0; i < 32; i++)
			model_gpr[i] = '0;
		repeat (3) @(posedge clk);
		#10;
		rst_n = 1'b1;
	endtask

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			test_err[cur_test]++;
			$display("Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic report_test(input int t);
		if (!reported[t] && issued_all[t] && pending[t] == 0) begin
			reported[t] = 1'b1;
			$display("test %0d (%s) done with %0d errors", t, test_name[t], test_err[t]);
		end
	endtask

	always @(negedge clk) begin : monitor
		expect_t e;
		if (retire.valid) begin
			if (!first_seen) begin
				first_seen = 1'b1;
				cur_test = 0;
				check("cycles from issue to first retire", 32'(cyc - issue_cyc), 32'd3);
			end
			if (exp_q.size() == 0) begin
				n_errors++;
				$display("unexpected retire at time %0t with nothing outstanding", $time);
			end else begin
				e = exp_q.pop_front();
				cur_test = int'(e.test);
				check("wr_en", {31'd0, retire.wr_en}, {31'd0, e.exp.wr_en});
				if (e.exp.wr_en) begin
					check("wr_idx", {27'd0, retire.wr_idx}, {27'd0, e.exp.wr_idx});
					check("value", retire.value, e.exp.value);
					if (e.hand)
						check("value vs table", retire.value, e.value);
				end
				check("cr0_wr", {31'd0, retire.cr0_wr}, {31'd0, e.exp.cr0_wr});
				if (e.exp.cr0_wr) begin
					check("cr0", {28'd0, retire.cr0}, {28'd0, e.exp.cr0});
					if (e.hand)
						check("cr0 vs table", {28'd0, retire.cr0}, {28'd0, e.cr0});
				end
				pending[cur_test]--;
				report_test(cur_test);
			end
		end
	end

	initial begin : stimulus
		ppc_pkg::retire_t r;
		expect_t e;
		logic [15:0] g;
		int t;
		rst_n = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		lcg_state = 32'd68;
		model_so = 1'b0;
		for (int i = 0; i < 32; i++)
			model_gpr[i] = '0;
		for (int i = 0; i < n_tests; i++) begin
			pending[i] = 0;
			test_err[i] = 0;
			issued_all[i] = 1'b0;
			reported[i] = 1'b0;
		end
		test_name[0] = "reset and latency";
		test_name[1] = "immediates";
		test_name[2] = "dependencies";
		test_name[3] = "rotate";
		test_name[4] = "overflow";
		test_name[5] = "random stream";

		add_row(d_form(ppc_pkg::op_addi, 3, 0, 16'h1234), 32'h0000_1234, 4'b0000, 0);
		add_row(d_form(ppc_pkg::op_addis, 4, 0, 16'h8001), 32'h8001_0000, 4'b0000, 1);
		add_row(d_form(ppc_pkg::op_addi, 5, 3, 16'hffff), 32'h0000_1233, 4'b0000, 1);
		add_row(d_form(ppc_pkg::op_ori, 4, 6, 16'h00f0), 32'h8001_00f0, 4'b0000, 1);
		add_row(d_form(ppc_pkg::op_andi_rc, 4, 7, 16'h8000), 32'h0000_0000, 4'b0010, 1);
		add_row(d_form(ppc_pkg::op_andi_rc, 6, 8, 16'h00f0), 32'h0000_00f0, 4'b0100, 1);
		add_row(d_form(ppc_pkg::op_addi, 22, 0, 16'h8000), 32'hffff_8000, 4'b0000, 1);
		add_row(x_form(9, 3, 5, 0, ppc_pkg::xo_add, 0), 32'h0000_2467, 4'b0000, 2);
		add_row(x_form(10, 9, 3, 0, ppc_pkg::xo_subf, 1), 32'hffff_edcd, 4'b1000, 2);
		add_row(x_form(10, 11, 9, 0, ppc_pkg::xo_xor, 0), 32'hffff_c9aa, 4'b0000, 2);
		add_row(x_form(11, 12, 4, 0, ppc_pkg::xo_and, 1), 32'h8001_0000, 4'b1000, 2);
		add_row(x_form(10, 13, 11, 0, ppc_pkg::xo_or, 1), 32'hffff_edef, 4'b1000, 2);
		add_row(x_form(14, 13, 13, 0, ppc_pkg::xo_add, 0), 32'hffff_dbde, 4'b0000, 2);
		add_row(rlw_form(3, 15, 8, 16, 23, 0), 32'h0000_3400, 4'b0000, 3);
		add_row(rlw_form(4, 16, 4, 28, 3, 1), 32'h0000_0008, 4'b0100, 3); // wrapped mask
		add_row(rlw_form(14, 17, 0, 0, 31, 0), 32'hffff_dbde, 4'b0000, 3);
		add_row(d_form(ppc_pkg::op_addis, 18, 0, 16'h7fff), 32'h7fff_0000, 4'b0000, 4);
		add_row(x_form(19, 18, 18, 1, ppc_pkg::xo_add, 1), 32'hfffe_0000, 4'b1001, 4);
		reset_slot = slots.size(); // clear the sticky so before subfo.
		add_row(d_form(ppc_pkg::op_addis, 18, 0, 16'h7fff), 32'h7fff_0000, 4'b0000, 4);
		add_row(d_form(ppc_pkg::op_addis, 4, 0, 16'h8001), 32'h8001_0000, 4'b0000, 4);
		add_row(x_form(20, 4, 18, 1, ppc_pkg::xo_subf, 1), 32'hfffe_0000, 4'b1001, 4);
		add_row(x_form(21, 18, 0, 0, ppc_pkg::xo_add, 1), 32'h7fff_0000, 4'b0101, 4);
		add_row(32'h0000_0000, 32'h0, 4'b0000, 5); // opcode 0 retires without a write
		for (int i = 0; i < n_random; i++) begin
			push_slot(1'b1, 1'b0, rand_instr(), '0, 4'd0, 5);
			g = lcg_next();
			if (g[15:14] == 2'b00) begin
				push_slot(1'b0, 1'b0, 32'd0, '0, 4'd0, 5);
				if (g[13])
					push_slot(1'b0, 1'b0, 32'd0, '0, 4'd0, 5);
			end
		end
		limit = slots.size() + 6 + 8 + 20; // two resets and one drain

		repeat (3) @(posedge clk);
		#10;
		rst_n = 1'b1;
		for (int i = 0; i < slots.size(); i++) begin
			if (i == reset_slot)
				restart_core();
			@(posedge clk);
			#10;
			instr_valid = slots[i].valid;
			instr = slots[i].word;
			t = int'(slots[i].test);
			if (slots[i].valid) begin
				if (issue_cyc < 0)
					issue_cyc = cyc + 1; // sampled on the next edge
				model_step(slots[i].word, r);
				e.exp = r;
				e.hand = slots[i].hand;
				e.value = slots[i].value;
				e.cr0 = slots[i].cr0;
				e.test = slots[i].test;
				exp_q.push_back(e);
				pending[t]++;
			end
			if (i == slots.size() - 1)
				issued_all[t] = 1'b1;
			else if (slots[i + 1].test != slots[i].test)
				issued_all[t] = 1'b1;
			report_test(t);
		end
		@(posedge clk);
		#10;
		instr_valid = 1'b0;
		instr = '0;
		while (exp_q.size() != 0)
			@(posedge clk);
		repeat (2) @(posedge clk);
		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// ==== src/ppc_alu.sv ====
module ppc_alu (
	input  ppc_pkg::word_t a,
	input  ppc_pkg::word_t b,
	input  ppc_pkg::ctrl_t ctrl,
	input  logic so_in,
	output ppc_pkg::word_t result,
	output ppc_pkg::cr0_t cr0,
	output logic ov
);

	localparam int msb = ppc_pkg::xlen - 1;

	ppc_pkg::word_t sum;
	ppc_pkg::word_t diff;
	ppc_pkg::word_t rot;
	ppc_pkg::word_t mask_lo;
	ppc_pkg::word_t mask_hi;
	ppc_pkg::word_t mask;
	logic [2*ppc_pkg::xlen-1:0] rot_dbl;

	assign sum = a + b;
	assign diff = b - a; // subf is rB - rA

	assign rot_dbl = {a, a} << ctrl.sh;
	assign rot = rot_dbl[2*ppc_pkg::xlen-1 -: ppc_pkg::xlen];

	// mb and me count from the msb
	assign mask_lo = {ppc_pkg::xlen{1'b1}} >> ctrl.mb;
	assign mask_hi = ~({1'b0, {msb{1'b1}}} >> ctrl.me);
	assign mask = (ctrl.mb <= ctrl.me) ? (mask_lo & mask_hi)
		: (mask_lo | mask_hi); // wrapped mask

	always_comb begin
		ov = 1'b0;
		case (ctrl.alu_op)
			ppc_pkg::add: begin
				result = sum;
				ov = (a[msb] == b[msb]) && (sum[msb] != a[msb]);
			end
			ppc_pkg::sub: begin
				result = diff;
				ov = (a[msb] != b[msb]) && (diff[msb] != b[msb]);
			end
			ppc_pkg::and_op: result = a & b;
			ppc_pkg::or_op: result = a | b;
			ppc_pkg::xor_op: result = a ^ b;
			ppc_pkg::rotl_mask: result = rot & mask;
			default: result = '0;
		endcase
	end

	always_comb begin
		cr0.eq = (result == '0);
		cr0.lt = result[msb]; // signed compare with 0
		cr0.gt = !result[msb] && !cr0.eq;
		cr0.so = so_in | (ctrl.oe & ov);
	end

endmodule

// ==== src/ppc_bypass.sv ====
module ppc_bypass (
	input  ppc_pkg::reg_idx_t e_ra,
	input  ppc_pkg::reg_idx_t e_rb,
	input  ppc_pkg::reg_idx_t e_rs,
	input  logic m_wr_en,
	input  logic w_wr_en,
	input  ppc_pkg::reg_idx_t m_idx,
	input  ppc_pkg::reg_idx_t w_idx,
	output logic [1:0] sel_a,
	output logic [1:0] sel_b,
	output logic [1:0] sel_s
);

	// youngest producer wins
	function automatic logic [1:0] pick(
		input ppc_pkg::reg_idx_t src,
		input logic m_en,
		input ppc_pkg::reg_idx_t m_dst,
		input logic w_en,
		input ppc_pkg::reg_idx_t w_dst
	);
		if (m_en && m_dst == src) begin
			return ppc_pkg::fwd_m;
		end
		if (w_en && w_dst == src) begin
			return ppc_pkg::fwd_w;
		end
		return ppc_pkg::fwd_rf;
	endfunction

	assign sel_a = pick(e_ra, m_wr_en, m_idx, w_wr_en, w_idx);
	assign sel_b = pick(e_rb, m_wr_en, m_idx, w_wr_en, w_idx);
	assign sel_s = pick(e_rs, m_wr_en, m_idx, w_wr_en, w_idx);

endmodule

// ==== src/ppc_core.sv ====
module ppc_core (
	input  logic clk,
	input  logic rst_n,
	input  logic instr_valid,
	input  ppc_pkg::instr_t instr,
	output ppc_pkg::retire_t retire
);

	logic d_valid;
	ppc_pkg::instr_t d_instr;
	ppc_pkg::ctrl_t d_ctrl;
	ppc_pkg::reg_idx_t d_ra;
	ppc_pkg::reg_idx_t d_rb;
	ppc_pkg::reg_idx_t d_rs;
	ppc_pkg::word_t d_rd_s;
	ppc_pkg::word_t d_rd_a;
	ppc_pkg::word_t d_rd_b;

	logic e_valid;
	ppc_pkg::ctrl_t e_ctrl;
	ppc_pkg::reg_idx_t e_ra;
	ppc_pkg::reg_idx_t e_rb;
	ppc_pkg::reg_idx_t e_rs;
	logic [15:0] e_imm;
	ppc_pkg::word_t e_rd_s;
	ppc_pkg::word_t e_rd_a;
	ppc_pkg::word_t e_rd_b;

	logic [1:0] sel_a;
	logic [1:0] sel_b;
	logic [1:0] sel_s;
	ppc_pkg::word_t fwd_a;
	ppc_pkg::word_t fwd_b;
	ppc_pkg::word_t fwd_s;
	ppc_pkg::word_t op_a;
	ppc_pkg::word_t op_b;

	ppc_pkg::word_t alu_result;
	ppc_pkg::cr0_t alu_cr0;
	logic alu_ov;
	logic xer_so;

	ppc_pkg::retire_t m_rec;
	ppc_pkg::retire_t w_rec;

	function automatic ppc_pkg::word_t fwd_mux(
		input logic [1:0] sel,
		input ppc_pkg::word_t rd,
		input ppc_pkg::word_t m_val,
		input ppc_pkg::word_t w_val
	);
		case (sel)
			ppc_pkg::fwd_m: return m_val;
			ppc_pkg::fwd_w: return w_val;
			default: return rd;
		endcase
	endfunction

	ppc_decode i_ppc_decode (
		.instr(d_instr),
		.valid(d_valid),
		.ctrl(d_ctrl),
		.ra(d_ra),
		.rb(d_rb),
		.rs(d_rs)
	);

	ppc_gpr i_ppc_gpr (
		.clk(clk),
		.rst_n(rst_n),
		.raddr1(d_rs),
		.raddr2(d_ra),
		.raddr3(d_rb),
		.rd1(d_rd_s),
		.rd2(d_rd_a),
		.rd3(d_rd_b),
		.wr_en(w_rec.wr_en),
		.waddr(w_rec.wr_idx),
		.wdata(w_rec.value)
	);

	ppc_bypass i_ppc_bypass (
		.e_ra(e_ra),
		.e_rb(e_rb),
		.e_rs(e_rs),
		.m_wr_en(m_rec.wr_en),
		.w_wr_en(w_rec.wr_en),
		.m_idx(m_rec.wr_idx),
		.w_idx(w_rec.wr_idx),
		.sel_a(sel_a),
		.sel_b(sel_b),
		.sel_s(sel_s)
	);

	ppc_alu i_ppc_alu (
		.a(op_a),
		.b(op_b),
		.ctrl(e_ctrl),
		.so_in(xer_so),
		.result(alu_result),
		.cr0(alu_cr0),
		.ov(alu_ov)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			d_valid <= 1'b0;
		end else begin
			d_valid <= instr_valid;
		end
	end

	always_ff @(posedge clk) begin
		d_instr <= instr;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			e_valid <= 1'b0;
			e_ctrl <= '0;
		end else begin
			e_valid <= d_valid;
			e_ctrl <= d_ctrl; // decode already idles invalid slots
		end
	end

	always_ff @(posedge clk) begin
		e_ra <= d_ra;
		e_rb <= d_rb;
		e_rs <= d_rs;
		e_imm <= d_instr[ppc_pkg::f_imm +: 16];
		e_rd_s <= d_rd_s;
		e_rd_a <= d_rd_a;
		e_rd_b <= d_rd_b;
	end

	assign fwd_a = fwd_mux(sel_a, e_rd_a, m_rec.value, w_rec.value);
	assign fwd_b = fwd_mux(sel_b, e_rd_b, m_rec.value, w_rec.value);
	assign fwd_s = fwd_mux(sel_s, e_rd_s, m_rec.value, w_rec.value);

	assign op_a = e_ctrl.a_zero ? '0 : (e_ctrl.a_is_rs ? fwd_s : fwd_a);

	always_comb begin
		case (e_ctrl.b_sel)
			ppc_pkg::gpr_rb: op_b = fwd_b;
			ppc_pkg::imm_signed: op_b = {{16{e_imm[15]}}, e_imm};
			ppc_pkg::imm_shifted: op_b = {e_imm, 16'h0000};
			default: op_b = {16'h0000, e_imm};
		endcase
	end

	// sticky summary overflow
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			xer_so <= 1'b0;
		end else if (e_valid && e_ctrl.oe && alu_ov) begin
			xer_so <= 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			m_rec <= '0;
		end else begin
			m_rec.valid <= e_valid;
			m_rec.wr_en <= e_valid & e_ctrl.wr_en;
			m_rec.wr_idx <= e_ctrl.wr_idx;
			m_rec.value <= alu_result;
			m_rec.cr0_wr <= e_valid & e_ctrl.rc;
			m_rec.cr0 <= alu_cr0;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			w_rec <= '0;
		end else begin
			w_rec <= m_rec;
		end
	end

	assign retire = w_rec; // gpr write lands on the next edge

endmodule

// ==== src/ppc_decode.sv ====
module ppc_decode (
	input  ppc_pkg::instr_t instr,
	input  logic valid,
	output ppc_pkg::ctrl_t ctrl,
	output ppc_pkg::reg_idx_t ra,
	output ppc_pkg::reg_idx_t rb,
	output ppc_pkg::reg_idx_t rs
);

	logic [5:0] opcd;
	logic [8:0] xo;
	logic rc_bit;
	logic oe_bit;

	assign opcd = instr[ppc_pkg::f_opcd +: 6];
	assign xo = instr[ppc_pkg::f_xo +: 9];
	assign rc_bit = instr[ppc_pkg::f_rc];
	assign oe_bit = instr[ppc_pkg::f_oe];

	assign rs = instr[ppc_pkg::f_rt +: 5]; // also rT
	assign ra = instr[ppc_pkg::f_ra +: 5];
	assign rb = instr[ppc_pkg::f_rb +: 5];

	always_comb begin
		// unknown or idle slot computes 0 & imm and writes nothing
		ctrl = '0;
		ctrl.alu_op = ppc_pkg::and_op;
		ctrl.b_sel = ppc_pkg::imm_zero;
		ctrl.a_zero = 1'b1;
		ctrl.sh = instr[ppc_pkg::f_sh +: 5];
		ctrl.mb = instr[ppc_pkg::f_mb +: 5];
		ctrl.me = instr[ppc_pkg::f_me +: 5];
		if (valid) begin
			case (opcd)
				ppc_pkg::op_addi, ppc_pkg::op_addis: begin
					ctrl.alu_op = ppc_pkg::add;
					ctrl.b_sel = (opcd == ppc_pkg::op_addis) ? ppc_pkg::imm_shifted
						: ppc_pkg::imm_signed;
					ctrl.a_zero = (ra == '0);
					ctrl.wr_en = 1'b1;
					ctrl.wr_idx = rs;
				end
				ppc_pkg::op_ori, ppc_pkg::op_andi_rc: begin
					ctrl.alu_op = (opcd == ppc_pkg::op_ori) ? ppc_pkg::or_op : ppc_pkg::and_op;
					ctrl.a_zero = 1'b0;
					ctrl.a_is_rs = 1'b1;
					ctrl.wr_en = 1'b1;
					ctrl.wr_idx = ra;
					ctrl.rc = (opcd == ppc_pkg::op_andi_rc); // andi. always records
				end
				ppc_pkg::op_rlwinm: begin
					ctrl.alu_op = ppc_pkg::rotl_mask;
					ctrl.a_zero = 1'b0;
					ctrl.a_is_rs = 1'b1;
					ctrl.wr_en = 1'b1;
					ctrl.wr_idx = ra;
					ctrl.rc = rc_bit;
				end
				ppc_pkg::op_x: begin
					ctrl.b_sel = ppc_pkg::gpr_rb;
					ctrl.a_zero = 1'b0;
					ctrl.rc = rc_bit;
					ctrl.wr_en = 1'b1;
					case (xo)
						ppc_pkg::xo_add, ppc_pkg::xo_subf: begin
							ctrl.alu_op = (xo == ppc_pkg::xo_add) ? ppc_pkg::add : ppc_pkg::sub;
							ctrl.oe = oe_bit;
							ctrl.wr_idx = rs;
						end
						ppc_pkg::xo_and, ppc_pkg::xo_or, ppc_pkg::xo_xor: begin
							ctrl.alu_op = (xo == ppc_pkg::xo_and) ? ppc_pkg::and_op
								: (xo == ppc_pkg::xo_or) ? ppc_pkg::or_op : ppc_pkg::xor_op;
							ctrl.a_is_rs = 1'b1;
							ctrl.wr_idx = ra;
						end
						default: begin
							ctrl.rc = 1'b0;
							ctrl.wr_en = 1'b0;
							ctrl.a_zero = 1'b1;
							ctrl.b_sel = ppc_pkg::imm_zero;
						end
					endcase
				end
				default: ;
			endcase
		end
	end

endmodule

// ==== src/ppc_gpr.sv ====
module ppc_gpr (
	input  logic clk,
	input  logic rst_n,
	input  ppc_pkg::reg_idx_t raddr1,
	input  ppc_pkg::reg_idx_t raddr2,
	input  ppc_pkg::reg_idx_t raddr3,
	output ppc_pkg::word_t rd1,
	output ppc_pkg::word_t rd2,
	output ppc_pkg::word_t rd3,
	input  logic wr_en,
	input  ppc_pkg::reg_idx_t waddr,
	input  ppc_pkg::word_t wdata
);

	ppc_pkg::word_t regs [ppc_pkg::gpr_count];

	// same-cycle write shows up on the read
	function automatic ppc_pkg::word_t read_port(input ppc_pkg::reg_idx_t addr);
		if (wr_en && waddr == addr) begin
			return wdata;
		end
		return regs[addr];
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < ppc_pkg::gpr_count; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[waddr] <= wdata;
		end
	end

	always_comb begin
		rd1 = read_port(raddr1);
		rd2 = read_port(raddr2);
		rd3 = read_port(raddr3);
	end

endmodule

// ==== src/ppc_pkg.sv ====
package ppc_pkg;

	localparam int xlen = 32;
	localparam int gpr_count = 32;

	typedef logic [$clog2(gpr_count)-1:0] reg_idx_t;
	typedef logic [xlen-1:0] word_t;
	typedef logic [0:31] instr_t; // bit 0 is the msb

	// start bit of each instruction field
	localparam int f_opcd = 0;
	localparam int f_rt = 6; // rT and rS share this slot
	localparam int f_ra = 11;
	localparam int f_rb = 16;
	localparam int f_imm = 16;
	localparam int f_sh = 16;
	localparam int f_mb = 21;
	localparam int f_me = 26;
	localparam int f_oe = 21;
	localparam int f_xo = 22; // 9 bit xo, covers X and XO forms here
	localparam int f_rc = 31;

	localparam logic [5:0] op_addi = 6'd14;
	localparam logic [5:0] op_addis = 6'd15;
	localparam logic [5:0] op_ori = 6'd24;
	localparam logic [5:0] op_andi_rc = 6'd28;
	localparam logic [5:0] op_rlwinm = 6'd21;
	localparam logic [5:0] op_x = 6'd31;

	localparam logic [8:0] xo_add = 9'd266;
	localparam logic [8:0] xo_subf = 9'd40;
	localparam logic [8:0] xo_and = 9'd28;
	localparam logic [8:0] xo_or = 9'd444;
	localparam logic [8:0] xo_xor = 9'd316;

	// forwarding source select
	localparam logic [1:0] fwd_rf = 2'd0;
	localparam logic [1:0] fwd_m = 2'd1;
	localparam logic [1:0] fwd_w = 2'd2;

	typedef enum logic [2:0] {
		add,
		sub,
		and_op,
		or_op,
		xor_op,
		rotl_mask
	} alu_op_e;

	typedef enum logic [1:0] {
		gpr_rb,
		imm_signed,
		imm_shifted, // imm << 16
		imm_zero
	} b_sel_e;

	typedef struct packed {
		alu_op_e alu_op;
		b_sel_e b_sel;
		logic a_zero; // rA of 0 reads as literal 0
		logic a_is_rs;
		logic wr_en;
		reg_idx_t wr_idx;
		logic rc;
		logic oe;
		logic [4:0] sh;
		logic [4:0] mb;
		logic [4:0] me;
	} ctrl_t;

	typedef struct packed {
		logic lt;
		logic gt;
		logic eq;
		logic so;
	} cr0_t;

	typedef struct packed {
		logic valid;
		logic wr_en;
		reg_idx_t wr_idx;
		word_t value;
		logic cr0_wr;
		cr0_t cr0;
	} retire_t;

endpackage
